// ==== include/flight_cfg.svh ====
`ifndef FLIGHT_CFG_SVH
`define FLIGHT_CFG_SVH

// Receiver stick value width, 0 to 255
`define REC_VAL_BIT_WIDTH     8
// Signed angle, gyro and correction width
`define RATE_BIT_WIDTH        16
`define MOTOR_RATE_BIT_WIDTH  8
// Stick neutral position
`define STICK_CENTER          128

// Controller gains as right shifts
`define ANGLE_GAIN_SHIFT      2
`define RATE_DAMP_SHIFT       3

// Mixer limits
`define IDLE_THROTTLE         10
`define MOTOR_MAX             250

// ESC PWM timing, sys_clk cycles per us tick
`define US_DIV                4
`define PWM_FRAME_TICKS       400
`define PWM_MIN_PULSE         100
`define PWM_TICK_BIT_WIDTH    9

`endif

// ==== source/flight_types_pkg.sv ====
`include "flight_cfg.svh"

package flight_types_pkg;

    // Angle mode levels the frame, rate mode holds body rates
    typedef enum logic {
        MODE_ANGLE,
        MODE_RATE
    } flight_mode_t;

    // One stage per state, ack held until req drops
    typedef enum logic [1:0] {
        S_IDLE,
        S_ATTITUDE,
        S_MIX,
        S_ACK
    } seq_state_t;

    // Receiver sticks
    typedef struct packed {
        logic [`REC_VAL_BIT_WIDTH-1:0] throttle;
        logic [`REC_VAL_BIT_WIDTH-1:0] roll;
        logic [`REC_VAL_BIT_WIDTH-1:0] pitch;
        logic [`REC_VAL_BIT_WIDTH-1:0] yaw;
    } stick_t;

    // IMU Euler angles and gyro rates
    typedef struct packed {
        logic signed [`RATE_BIT_WIDTH-1:0] roll_angle;
        logic signed [`RATE_BIT_WIDTH-1:0] pitch_angle;
        logic signed [`RATE_BIT_WIDTH-1:0] roll_rate;
        logic signed [`RATE_BIT_WIDTH-1:0] pitch_rate;
        logic signed [`RATE_BIT_WIDTH-1:0] yaw_rate;
    } imu_t;

    // Full frame from the sampler
    typedef struct packed {
        stick_t       stick;
        imu_t         imu;
        flight_mode_t mode;
    } sample_t;

    // Per-axis correction rates into the mixer
    typedef struct packed {
        logic signed [`RATE_BIT_WIDTH-1:0] roll;
        logic signed [`RATE_BIT_WIDTH-1:0] pitch;
        logic signed [`RATE_BIT_WIDTH-1:0] yaw;
    } axis_rate_t;

endpackage

// ==== source/motor_types_pkg.sv ====
`include "flight_cfg.svh"

package motor_types_pkg;

    // Motor rates 0 to MOTOR_MAX, quad-X numbering
    typedef struct packed {
        logic [`MOTOR_RATE_BIT_WIDTH-1:0] m1;
        logic [`MOTOR_RATE_BIT_WIDTH-1:0] m2;
        logic [`MOTOR_RATE_BIT_WIDTH-1:0] m3;
        logic [`MOTOR_RATE_BIT_WIDTH-1:0] m4;
    } motor_rate_t;

    // ESC pulse lines
    typedef struct packed {
        logic m1;
        logic m2;
        logic m3;
        logic m4;
    } motor_pwm_t;

endpackage

// ==== source/flight_sequencer.sv ====
module flight_sequencer (
    input  logic sys_clk,
    input  logic resetn,
    input  logic sample_req,
    output logic sample_ack,
    output logic attitude_en,
    output logic mix_en
);

    flight_types_pkg::seq_state_t state;

    // Frame walk: idle, attitude, mix, then hold ack
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            state      <= flight_types_pkg::S_IDLE;
            sample_ack <= 1'b0;
        end else begin
            case (state)
                flight_types_pkg::S_IDLE: begin
                    // New frame only once previous ack is low
                    if (sample_req) begin
                        state <= flight_types_pkg::S_ATTITUDE;
                    end
                end
                flight_types_pkg::S_ATTITUDE: begin
                    state <= flight_types_pkg::S_MIX;
                end
                flight_types_pkg::S_MIX: begin
                    // Mixer result lands on this edge
                    state <= flight_types_pkg::S_ACK;
                end
                flight_types_pkg::S_ACK: begin
                    // Ack follows req, so it rises one cycle after the mix
                    // and falls one cycle after req is seen low
                    sample_ack <= sample_req;
                    if (!sample_req) begin
                        state <= flight_types_pkg::S_IDLE;
                    end
                end
                default: begin
                    state      <= flight_types_pkg::S_IDLE;
                    sample_ack <= 1'b0;
                end
            endcase
        end
    end

    // Stage strobes, one cycle each
    assign attitude_en = (state == flight_types_pkg::S_ATTITUDE);
    assign mix_en      = (state == flight_types_pkg::S_MIX);

endmodule

// ==== source/attitude_controller.sv ====
`include "flight_cfg.svh"

module attitude_controller (
    input  logic                          sys_clk,
    input  logic                          resetn,
    input  logic                          attitude_en,
    input  flight_types_pkg::sample_t     sample,
    output flight_types_pkg::axis_rate_t  rates
);

    localparam int RW = `RATE_BIT_WIDTH;

    // Stick offsets around center
    logic signed [RW-1:0] roll_off;
    logic signed [RW-1:0] pitch_off;
    logic signed [RW-1:0] yaw_off;
    // Angle-mode error terms
    logic signed [RW-1:0] roll_angle_term;
    logic signed [RW-1:0] pitch_angle_term;
    // Gyro damping
    logic signed [RW-1:0] roll_damp;
    logic signed [RW-1:0] pitch_damp;
    logic signed [RW-1:0] yaw_damp;
    // Mode-selected commands before damping
    logic signed [RW-1:0] roll_cmd;
    logic signed [RW-1:0] pitch_cmd;

    always_comb begin
        // Zero-extended stick minus center, signed result
        roll_off  = RW'(sample.stick.roll) - RW'(`STICK_CENTER);
        pitch_off = RW'(sample.stick.pitch) - RW'(`STICK_CENTER);
        yaw_off   = RW'(sample.stick.yaw) - RW'(`STICK_CENTER);

        // Target angle minus measured angle, scaled down
        roll_angle_term  = (roll_off - signed'(sample.imu.roll_angle)) >>> `ANGLE_GAIN_SHIFT;
        pitch_angle_term = (pitch_off - signed'(sample.imu.pitch_angle)) >>> `ANGLE_GAIN_SHIFT;

        roll_damp  = signed'(sample.imu.roll_rate) >>> `RATE_DAMP_SHIFT;
        pitch_damp = signed'(sample.imu.pitch_rate) >>> `RATE_DAMP_SHIFT;
        yaw_damp   = signed'(sample.imu.yaw_rate) >>> `RATE_DAMP_SHIFT;

        // Rate mode uses the raw stick offset
        if (sample.mode == flight_types_pkg::MODE_ANGLE) begin
            roll_cmd  = roll_angle_term;
            pitch_cmd = pitch_angle_term;
        end else begin
            roll_cmd  = roll_off;
            pitch_cmd = pitch_off;
        end
    end

    // Yaw is always a rate command
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            rates <= '0;
        end else if (attitude_en) begin
            rates.roll  <= roll_cmd - roll_damp;
            rates.pitch <= pitch_cmd - pitch_damp;
            rates.yaw   <= yaw_off - yaw_damp;
        end
    end

endmodule

// ==== source/motor_mixer.sv ====
`include "flight_cfg.svh"

module motor_mixer (
    input  logic                               sys_clk,
    input  logic                               resetn,
    input  logic                               mix_en,
    input  logic [`REC_VAL_BIT_WIDTH-1:0]      throttle,
    input  flight_types_pkg::axis_rate_t       rates,
    output motor_types_pkg::motor_rate_t       motor_rates
);

    localparam int MW = `MOTOR_RATE_BIT_WIDTH;
    // Two guard bits for a four-term sum
    localparam int SW = `RATE_BIT_WIDTH + 2;

    logic signed [SW-1:0] thr_s;
    logic signed [SW-1:0] roll_s;
    logic signed [SW-1:0] pitch_s;
    logic signed [SW-1:0] yaw_s;
    logic signed [SW-1:0] sum1;
    logic signed [SW-1:0] sum2;
    logic signed [SW-1:0] sum3;
    logic signed [SW-1:0] sum4;

    // Saturate to 0..MOTOR_MAX
    function automatic logic [MW-1:0] clamp_rate(input logic signed [SW-1:0] sum);
        if (sum < 0) begin
            return '0;
        end else if (sum > SW'(`MOTOR_MAX)) begin
            return MW'(`MOTOR_MAX);
        end
        return sum[MW-1:0];
    endfunction

    always_comb begin
        thr_s   = SW'({1'b0, throttle});
        roll_s  = SW'(signed'(rates.roll));
        pitch_s = SW'(signed'(rates.pitch));
        yaw_s   = SW'(signed'(rates.yaw));

        // Quad-X: m1 front right, m2 front left, m3 rear left, m4 rear right
        sum1 = thr_s + roll_s + pitch_s - yaw_s;
        sum2 = thr_s - roll_s + pitch_s + yaw_s;
        sum3 = thr_s - roll_s - pitch_s - yaw_s;
        sum4 = thr_s + roll_s - pitch_s + yaw_s;
    end

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            motor_rates <= '0;
        end else if (mix_en) begin
            // Idle cut-off, motors stopped at low throttle
            if (throttle < `REC_VAL_BIT_WIDTH'(`IDLE_THROTTLE)) begin
                motor_rates <= '0;
            end else begin
                motor_rates.m1 <= clamp_rate(sum1);
                motor_rates.m2 <= clamp_rate(sum2);
                motor_rates.m3 <= clamp_rate(sum3);
                motor_rates.m4 <= clamp_rate(sum4);
            end
        end
    end

endmodule

// ==== source/pwm_timer.sv ====
`include "flight_cfg.svh"

module pwm_timer (
    input  logic                            sys_clk,
    input  logic                            resetn,
    output logic [`PWM_TICK_BIT_WIDTH-1:0]  tick_count,
    output logic                            frame_start
);

    localparam int DW = $clog2(`US_DIV + 1);
    localparam int TW = `PWM_TICK_BIT_WIDTH;

    logic [DW-1:0] prescale;
    logic          tick;

    // One-cycle enable per microsecond
    assign tick = (prescale == DW'(`US_DIV - 1));

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            prescale    <= '0;
            tick_count  <= '0;
            frame_start <= 1'b0;
        end else begin
            frame_start <= 1'b0;
            prescale    <= tick ? '0 : prescale + 1'b1;
            if (tick) begin
                // Wrap marks the start of the next ESC frame
                if (tick_count == TW'(`PWM_FRAME_TICKS - 1)) begin
                    tick_count  <= '0;
                    frame_start <= 1'b1;
                end else begin
                    tick_count <= tick_count + 1'b1;
                end
            end
        end
    end

endmodule

// ==== source/esc_pwm.sv ====
`include "flight_cfg.svh"

module esc_pwm (
    input  logic                            sys_clk,
    input  logic                            resetn,
    input  logic                            frame_start,
    input  logic [`PWM_TICK_BIT_WIDTH-1:0]  tick_count,
    input  motor_types_pkg::motor_rate_t    motor_rates,
    output motor_types_pkg::motor_pwm_t     motor_pwm
);

    // One spare bit so min pulse plus max rate cannot wrap
    localparam int CW = `PWM_TICK_BIT_WIDTH + 1;

    motor_types_pkg::motor_rate_t frame_rates;

    // High while inside min pulse plus rate
    function automatic logic pulse_on(input logic [`MOTOR_RATE_BIT_WIDTH-1:0] rate,
                                      input logic [`PWM_TICK_BIT_WIDTH-1:0] count);
        logic [CW-1:0] width;
        width = CW'(`PWM_MIN_PULSE) + CW'(rate);
        return (CW'(count) < width);
    endfunction

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            frame_rates <= '0;
            motor_pwm   <= '0;
        end else begin
            // New width only at frame boundary
            if (frame_start) begin
                frame_rates <= motor_rates;
            end
            motor_pwm.m1 <= pulse_on(frame_rates.m1, tick_count);
            motor_pwm.m2 <= pulse_on(frame_rates.m2, tick_count);
            motor_pwm.m3 <= pulse_on(frame_rates.m3, tick_count);
            motor_pwm.m4 <= pulse_on(frame_rates.m4, tick_count);
        end
    end

endmodule

// ==== source/flight_core.sv ====
`include "flight_cfg.svh"

module flight_core (
    input  logic                          sys_clk,
    input  logic                          resetn,
    input  logic                          sample_req,
    input  flight_types_pkg::sample_t     sample,
    output logic                          sample_ack,
    output motor_types_pkg::motor_rate_t  motor_rates,
    output motor_types_pkg::motor_pwm_t   motor_pwm
);

    // Stage strobes
    logic attitude_en;
    logic mix_en;
    // Controller to mixer
    flight_types_pkg::axis_rate_t rates;
    // PWM frame timing
    logic [`PWM_TICK_BIT_WIDTH-1:0] tick_count;
    logic                           frame_start;

    flight_sequencer u_sequencer (
        .sys_clk     (sys_clk),
        .resetn      (resetn),
        .sample_req  (sample_req),
        .sample_ack  (sample_ack),
        .attitude_en (attitude_en),
        .mix_en      (mix_en)
    );

    attitude_controller u_attitude (
        .sys_clk     (sys_clk),
        .resetn      (resetn),
        .attitude_en (attitude_en),
        .sample      (sample),
        .rates       (rates)
    );

    // Throttle straight from the held frame
    motor_mixer u_mixer (
        .sys_clk     (sys_clk),
        .resetn      (resetn),
        .mix_en      (mix_en),
        .throttle    (sample.stick.throttle),
        .rates       (rates),
        .motor_rates (motor_rates)
    );

    pwm_timer u_timer (
        .sys_clk     (sys_clk),
        .resetn      (resetn),
        .tick_count  (tick_count),
        .frame_start (frame_start)
    );

    esc_pwm u_esc (
        .sys_clk     (sys_clk),
        .resetn      (resetn),
        .frame_start (frame_start),
        .tick_count  (tick_count),
        .motor_rates (motor_rates),
        .motor_pwm   (motor_pwm)
    );

endmodule

// ==== test/flight_core_properties.sv ====
module flight_core_properties (
    input logic                        sys_clk,
    input logic                        resetn,
    input logic                        sample_req,
    input logic                        sample_ack,
    input logic                        attitude_en,
    input logic                        mix_en,
    input motor_types_pkg::motor_pwm_t motor_pwm
);

    // Failed assertions, read at the end of the run
    int unsigned fail_count = 0;

    // Ack only answers a pending request
    ack_needs_req: assert property (@(posedge sys_clk) disable iff (!resetn)
        $rose(sample_ack) |-> $past(sample_req))
    else begin
        $error("sample_ack rose without sample_req");
        fail_count++;
    end

    // Ack held for as long as req is held
    ack_holds: assert property (@(posedge sys_clk) disable iff (!resetn)
        (sample_ack && sample_req) |=> sample_ack)
    else begin
        $error("sample_ack dropped while sample_req high");
        fail_count++;
    end

    // One stage strobe at a time
    strobes_exclusive: assert property (@(posedge sys_clk) disable iff (!resetn)
        !(attitude_en && mix_en))
    else begin
        $error("attitude_en and mix_en high together");
        fail_count++;
    end

    // ESC lines quiet right after reset
    pwm_reset_zero: assert property (@(posedge sys_clk)
        $past(!resetn) |-> (motor_pwm == '0))
    else begin
        $error("motor_pwm not zero after reset");
        fail_count++;
    end

endmodule

// ==== test/flight_core_tb.sv ====
`include "flight_cfg.svh"

module flight_core_tb;

    localparam int FRAME_CYCLES = `PWM_FRAME_TICKS * `US_DIV;
    localparam int ACK_RISE_CYCLES = 4;
    localparam int ACK_FALL_MAX = 2;
    localparam int REQ_HOLD_CYCLES = 2;

    logic                         sys_clk;
    logic                         resetn;
    logic                         sample_req;
    flight_types_pkg::sample_t    sample;
    logic                         sample_ack;
    motor_types_pkg::motor_rate_t motor_rates;
    motor_types_pkg::motor_pwm_t  motor_pwm;

    int errors;
    int checks;
    bit timed_out;
    // Model rates and rates seen at ack with m1 at index 0
    int model_m [4];
    int acked_m [4];

    flight_core u_dut (
        .sys_clk     (sys_clk),
        .resetn      (resetn),
        .sample_req  (sample_req),
        .sample      (sample),
        .sample_ack  (sample_ack),
        .motor_rates (motor_rates),
        .motor_pwm   (motor_pwm)
    );

    // Handshake rules on the sequencer with the PWM input tied off
    bind flight_sequencer flight_core_properties u_seq_props (
        .sys_clk     (sys_clk),
        .resetn      (resetn),
        .sample_req  (sample_req),
        .sample_ack  (sample_ack),
        .attitude_en (attitude_en),
        .mix_en      (mix_en),
        .motor_pwm   ('0)
    );

    // Reset value of the ESC lines
    bind esc_pwm flight_core_properties u_esc_props (
        .sys_clk     (sys_clk),
        .resetn      (resetn),
        .sample_req  (1'b0),
        .sample_ack  (1'b0),
        .attitude_en (1'b0),
        .mix_en      (1'b0),
        .motor_pwm   (motor_pwm)
    );

    always #10 sys_clk = ~sys_clk;

    function automatic int clamp_motor(input int sum);
        if (sum < 0) begin
            return 0;
        end
        if (sum > `MOTOR_MAX) begin
            return `MOTOR_MAX;
        end
        return sum;
    endfunction

    // Controller and quad-X mix with idle cut-off
    function automatic void run_model(input int mode, input int thr, input int st_roll,
                                      input int st_pitch, input int st_yaw, input int ra,
                                      input int pa, input int rr, input int pr, input int yr);
        int r;
        int p;
        int y;
        r = st_roll - `STICK_CENTER;
        p = st_pitch - `STICK_CENTER;
        // Angle mode steers toward the stick angle
        if (mode == 0) begin
            r = (r - ra) >>> `ANGLE_GAIN_SHIFT;
            p = (p - pa) >>> `ANGLE_GAIN_SHIFT;
        end
        r = r - (rr >>> `RATE_DAMP_SHIFT);
        p = p - (pr >>> `RATE_DAMP_SHIFT);
        y = st_yaw - `STICK_CENTER - (yr >>> `RATE_DAMP_SHIFT);
        if (thr < `IDLE_THROTTLE) begin
            model_m = '{0, 0, 0, 0};
        end else begin
            model_m[0] = clamp_motor(thr + r + p - y);
            model_m[1] = clamp_motor(thr - r + p + y);
            model_m[2] = clamp_motor(thr - r - p - y);
            model_m[3] = clamp_motor(thr + r - p + y);
        end
    endfunction

    // Cycles until ack reaches level or -1 on timeout
    task automatic wait_ack(input logic level, input int limit, output int cycles);
        cycles = -1;
        for (int i = 1; i <= limit; i++) begin
            @(negedge sys_clk);
            if (sample_ack == level) begin
                cycles = i;
                break;
            end
        end
    endtask

    // End of one pulse on all lines
    task automatic wait_pwm_fall(output bit ok);
        bit seen_high;
        ok = 1'b0;
        seen_high = 1'b0;
        for (int i = 0; i < 2 * FRAME_CYCLES; i++) begin
            @(negedge sys_clk);
            if (motor_pwm != '0) begin
                seen_high = 1'b1;
            end else if (seen_high) begin
                ok = 1'b1;
                break;
            end
        end
    endtask

    // High cycles per line over one full pulse
    task automatic measure_pwm(input string name, output bit ok);
        int high [4];
        int width;
        int want;
        bit started;
        ok = 1'b0;
        started = 1'b0;
        high = '{0, 0, 0, 0};
        for (int i = 0; i < 2 * FRAME_CYCLES; i++) begin
            @(negedge sys_clk);
            if (motor_pwm != '0) begin
                started = 1'b1;
                high[0] += int'(motor_pwm.m1);
                high[1] += int'(motor_pwm.m2);
                high[2] += int'(motor_pwm.m3);
                high[3] += int'(motor_pwm.m4);
            end else if (started) begin
                ok = 1'b1;
                break;
            end
        end
        if (ok) begin
            for (int k = 0; k < 4; k++) begin
                // Width in ticks with one tick of slack
                width = high[k] / `US_DIV;
                want = `PWM_MIN_PULSE + acked_m[k];
                checks++;
                if (width < want - 1 || width > want + 1) begin
                    errors++;
                    $display("ERR %s pwm_m%0d expected %0d actual %0d", name, k + 1, want, width);
                end
            end
        end
    endtask

    // One full handshake with rate check and PWM width
    task automatic run_frame(input string name);
        int rise;
        int fall;
        bit ok;
        sample_req = 1'b1;
        wait_ack(1'b1, 4 * ACK_RISE_CYCLES, rise);
        if (rise < 0) begin
            $display("%s: sample_ack never rose after sample_req", name);
            errors++;
            timed_out = 1'b1;
            return;
        end
        checks++;
        if (rise != ACK_RISE_CYCLES) begin
            errors++;
            $display("ERR %s ack_rise expected %0d actual %0d", name, ACK_RISE_CYCLES, rise);
        end
        // Rates already valid while ack is high
        acked_m[0] = int'(motor_rates.m1);
        acked_m[1] = int'(motor_rates.m2);
        acked_m[2] = int'(motor_rates.m3);
        acked_m[3] = int'(motor_rates.m4);
        for (int k = 0; k < 4; k++) begin
            checks++;
            if (acked_m[k] != model_m[k]) begin
                errors++;
                $display("ERR %s rate_m%0d expected %0d actual %0d",
                         name, k + 1, model_m[k], acked_m[k]);
            end
        end
        // Source keeps req up a little past the ack
        repeat (REQ_HOLD_CYCLES) @(negedge sys_clk);
        checks++;
        if (sample_ack !== 1'b1) begin
            errors++;
            $display("ERR %s ack_hold expected 1 actual %0d", name, sample_ack);
        end
        sample_req = 1'b0;
        wait_ack(1'b0, 4 * ACK_FALL_MAX, fall);
        if (fall < 0) begin
            $display("%s: sample_ack stayed high after sample_req dropped", name);
            errors++;
            timed_out = 1'b1;
            return;
        end
        checks++;
        if (fall > ACK_FALL_MAX) begin
            errors++;
            $display("ERR %s ack_fall expected <= %0d actual %0d", name, ACK_FALL_MAX, fall);
        end
        // Skip two pulse ends so the measured frame uses the new rates
        wait_pwm_fall(ok);
        if (ok) begin
            wait_pwm_fall(ok);
        end
        if (ok) begin
            measure_pwm(name, ok);
        end
        if (!ok) begin
            $display("%s: no complete PWM pulse seen in time", name);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    initial begin
        int fd;
        string line;
        string name;
        int mode;
        int thr;
        int sr;
        int sp;
        int sy;
        int ra;
        int pa;
        int rr;
        int pr;
        int yr;
        int exp_m [4];
        int frames;
        int asserts;
        void'($urandom(25));
        sys_clk = 1'b0;
        resetn = 1'b0;
        sample_req = 1'b0;
        sample = '0;
        errors = 0;
        checks = 0;
        frames = 0;
        timed_out = 1'b0;

        repeat (5) @(negedge sys_clk);
        checks += 2;
        if ({sample_ack, motor_rates, motor_pwm} != '0) begin
            errors++;
            $display("ERR reset outputs expected 0 actual %h",
                     {sample_ack, motor_rates, motor_pwm});
        end
        if (u_dut.tick_count != '0) begin
            errors++;
            $display("ERR reset tick_count expected 0 actual %0d", u_dut.tick_count);
        end
        resetn = 1'b1;

        fd = $fopen("test/flight_core_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open test/flight_core_input.txt");
            errors++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                void'($fgets(line, fd));
                // Comment and blank lines do not scan
                if ($sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                            mode, thr, sr, sp, sy, ra, pa, rr, pr, yr,
                            exp_m[0], exp_m[1], exp_m[2], exp_m[3]) == 14) begin
                    frames++;
                    name = $sformatf("frame%0d", frames);
                    run_model(mode, thr, sr, sp, sy, ra, pa, rr, pr, yr);
                    for (int k = 0; k < 4; k++) begin
                        checks++;
                        if (model_m[k] != exp_m[k]) begin
                            errors++;
                            $display("ERR %s model_m%0d expected %0d actual %0d",
                                     name, k + 1, exp_m[k], model_m[k]);
                        end
                    end
                    // Random idle gap between handshakes
                    repeat (int'($urandom % 8)) @(negedge sys_clk);
                    sample.mode = flight_types_pkg::flight_mode_t'(mode[0]);
                    sample.stick.throttle = 8'(thr);
                    sample.stick.roll = 8'(sr);
                    sample.stick.pitch = 8'(sp);
                    sample.stick.yaw = 8'(sy);
                    sample.imu.roll_angle = 16'(ra);
                    sample.imu.pitch_angle = 16'(pa);
                    sample.imu.roll_rate = 16'(rr);
                    sample.imu.pitch_rate = 16'(pr);
                    sample.imu.yaw_rate = 16'(yr);
                    run_frame(name);
                end
            end
            $fclose(fd);
        end
        if (frames == 0) begin
            $display("No frames were read from the input file");
            errors++;
        end

        asserts = int'(u_dut.u_sequencer.u_seq_props.fail_count)
                + int'(u_dut.u_esc.u_esc_props.fail_count);
        $display("Frames %0d, checks %0d, errors %0d, assertion failures %0d",
                 frames, checks, errors, asserts);
        if (errors == 0 && asserts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== test/flight_core_input.txt ====
# mode thr roll pitch yaw roll_ang pitch_ang roll_rate pitch_rate yaw_rate m1 m2 m3 m4
# mode 0 angle, 1 rate; sticks 0..255; IMU signed; last four are expected motor rates
0 128 128 128 128 0 0 0 0 0 128 128 128 128
0 100 160 128 128 0 0 0 0 0 108 92 92 108
0 120 128 128 128 40 -20 16 -24 0 116 140 124 100
0 150 100 140 150 3 -5 -9 7 17 128 180 132 160
0 240 255 255 128 -100 0 0 0 0 250 215 153 250
0 20 0 0 255 0 0 0 0 0 0 147 0 147
0 9 200 60 128 0 0 0 0 0 0 0 0 0
1 100 160 128 128 0 0 0 0 0 132 68 68 132
1 120 128 128 128 40 -20 16 -24 0 121 125 119 115
1 180 138 118 108 50 50 -40 40 -33 195 135 195 195
1 0 255 255 255 0 0 0 0 0 0 0 0 0
0 10 128 128 128 0 0 0 0 0 10 10 10 10

// ==== flist.f ====
+incdir+include
source/flight_types_pkg.sv
source/motor_types_pkg.sv
source/flight_sequencer.sv
source/attitude_controller.sv
source/motor_mixer.sv
source/pwm_timer.sv
source/esc_pwm.sv
source/flight_core.sv
test/flight_core_properties.sv
test/flight_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the flight_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=flight_core_sim

verilator --binary --timing --assert -Wno-fatal --top-module flight_core_tb \
    -f flist.f --Mdir "$OBJ" -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$OBJ/$BIN" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
    echo "Simulation result: pass"
    exit 0
fi
echo "Simulation result: fail, see $LOG"
exit 1
